// File: axi_to_fifo.f
common/axi_pkg.sv
common/mem_pkg.sv
hdl/bridge_fifo.sv
burst_gen/burst_gen.sv
hdl/cmd_serializer.sv
hdl/resp_router.sv
hdl/axi_to_fifo.sv
sim/axi_to_fifo_checker.sv
sim/axi_to_fifo_tb.sv

// File: burst_gen/burst_gen.sv
// Burst generator
// Holds one AXI address request and expands it into beats
// with address, byte mask and last flag

`timescale 1ns/1ns

module burst_gen (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               ax_valid_i,
  output logic               ax_ready_o,
  input  axi_pkg::axi_ax_t   ax_i,
  output logic               beat_valid_o,
  input  logic               beat_ready_i,
  output axi_pkg::axi_beat_t beat_o
);

  import axi_pkg::*;

  logic                  busy_q;
  logic [7:0]            cnt_q;
  logic [AXI_ADDR_W-1:0] addr_q;
  logic [AXI_ID_W-1:0]   id_q;
  logic [2:0]            size_q;
  logic [AXI_STRB_W-1:0] mask;

  assign ax_ready_o   = !busy_q;
  assign beat_valid_o = busy_q;

  // Control state
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (ax_valid_i && ax_ready_o) begin
      busy_q <= 1'b1;
      cnt_q  <= ax_i.len;
    end else if (beat_valid_o && beat_ready_i) begin
      busy_q <= (cnt_q != '0);
      cnt_q  <= cnt_q - 1'b1;
    end
  end

  // Request payload and an address that steps one 64-bit word per beat
  always_ff @(posedge clk_i) begin
    if (ax_valid_i && ax_ready_o) begin
      addr_q <= ax_i.addr;
      id_q   <= ax_i.id;
      size_q <= ax_i.size;
    end else if (beat_valid_o && beat_ready_i) begin
      addr_q <= addr_q + AXI_ADDR_W'(AXI_STRB_W);
    end
  end

  // Byte lanes of a naturally aligned access
  always_comb begin
    case (size_q)
      3'd0:    mask = AXI_STRB_W'(8'h01) << addr_q[2:0];
      3'd1:    mask = AXI_STRB_W'(8'h03) << {addr_q[2:1], 1'b0};
      3'd2:    mask = AXI_STRB_W'(8'h0f) << {addr_q[2], 2'b00};
      default: mask = '1;
    endcase
  end

  assign beat_o.addr = addr_q;
  assign beat_o.mask = mask;
  assign beat_o.id   = id_q;
  assign beat_o.last = (cnt_q == '0);

  a_legal_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ax_valid_i && ax_ready_o) |->
      (ax_i.burst == AXI_BURST_INCR) && (ax_i.size <= 3'd3) &&
      ((ax_i.size == 3'd3) || (ax_i.len == '0)));

endmodule

// File: common/axi_pkg.sv
// AXI4 package for the bridge
// Bus widths, response codes and the packed channel payloads

package axi_pkg;

  localparam int AXI_DATA_W = 64;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // Only INCR bursts are accepted
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_EXOKAY = 2'b01,
    AXI_RESP_SLVERR = 2'b10,
    AXI_RESP_DECERR = 2'b11
  } axi_resp_e;

  // AR and AW payload
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_ID_W-1:0]   id;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_ax_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    axi_resp_e           resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_ID_W-1:0]   id;
    logic                  last;
    axi_resp_e             resp;
  } axi_r_t;

  // One beat expanded from an address request
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_STRB_W-1:0] mask;
    logic [AXI_ID_W-1:0]   id;
    logic                  last;
  } axi_beat_t;

endpackage

// File: common/mem_pkg.sv
// Memory-side package for the bridge
// Command and response payloads, return tags and fifo depths

package mem_pkg;

  localparam int W_FIFO_DEPTH   = 2;
  // Also the limit on outstanding memory commands
  localparam int TAG_FIFO_DEPTH = 4;

  // Address is 8-byte aligned, data and wmask are zero for reads
  typedef struct packed {
    logic [axi_pkg::AXI_ADDR_W-1:0] addr;
    logic [axi_pkg::AXI_DATA_W-1:0] data;
    logic [axi_pkg::AXI_STRB_W-1:0] wmask;
    logic                           w;
  } mem_cmd_t;

  typedef struct packed {
    logic [axi_pkg::AXI_DATA_W-1:0] data;
  } mem_rsp_t;

  // Where a memory response has to go back to
  typedef struct packed {
    logic                         w;
    logic [axi_pkg::AXI_ID_W-1:0] id;
    logic                         last;
  } ret_tag_t;

endpackage

// File: hdl/axi_to_fifo.sv
// AXI4 to FIFO bridge
// Serializes AXI4 read and write bursts into one in-order stream of
// 64-bit memory commands and routes the responses back to R and B

`timescale 1ns/1ns

module axi_to_fifo (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  axi_pkg::axi_ax_t  ar_i,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  axi_pkg::axi_ax_t  aw_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  axi_pkg::axi_w_t   w_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output axi_pkg::axi_b_t   b_o,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output axi_pkg::axi_r_t   r_o,
  output logic              cmd_valid_o,
  input  logic              cmd_ready_i,
  output mem_pkg::mem_cmd_t cmd_o,
  input  logic              rsp_valid_i,
  output logic              rsp_ready_o,
  input  mem_pkg::mem_rsp_t rsp_i
);

  import axi_pkg::*;
  import mem_pkg::*;

  logic      rd_valid, rd_ready, wr_valid, wr_ready;
  axi_beat_t rd_beat, wr_beat;
  logic      wd_valid, wd_ready;
  axi_w_t    wd;
  logic      tag_in_valid, tag_in_ready, tag_out_valid, tag_out_ready;
  ret_tag_t  tag_in, tag_out;

  burst_gen rd_gen (
    .clk_i, .arst_n_i,
    .ax_valid_i(ar_valid_i), .ax_ready_o(ar_ready_o), .ax_i(ar_i),
    .beat_valid_o(rd_valid), .beat_ready_i(rd_ready), .beat_o(rd_beat)
  );

  burst_gen wr_gen (
    .clk_i, .arst_n_i,
    .ax_valid_i(aw_valid_i), .ax_ready_o(aw_ready_o), .ax_i(aw_i),
    .beat_valid_o(wr_valid), .beat_ready_i(wr_ready), .beat_o(wr_beat)
  );

  bridge_fifo #(.payload_t(axi_w_t), .depth_p(W_FIFO_DEPTH)) w_fifo (
    .clk_i, .arst_n_i,
    .in_valid_i(w_valid_i), .in_ready_o(w_ready_o), .in_data_i(w_i),
    .out_valid_o(wd_valid), .out_ready_i(wd_ready), .out_data_o(wd)
  );

  // Depth bounds the number of commands in flight
  bridge_fifo #(.payload_t(ret_tag_t), .depth_p(TAG_FIFO_DEPTH)) tag_fifo (
    .clk_i, .arst_n_i,
    .in_valid_i(tag_in_valid), .in_ready_o(tag_in_ready), .in_data_i(tag_in),
    .out_valid_o(tag_out_valid), .out_ready_i(tag_out_ready), .out_data_o(tag_out)
  );

  cmd_serializer u_serializer (
    .clk_i, .arst_n_i,
    .rd_valid_i(rd_valid), .rd_ready_o(rd_ready), .rd_beat_i(rd_beat),
    .wr_valid_i(wr_valid), .wr_ready_o(wr_ready), .wr_beat_i(wr_beat),
    .wd_valid_i(wd_valid), .wd_ready_o(wd_ready), .wd_i(wd),
    .cmd_valid_o, .cmd_ready_i, .cmd_o,
    .tag_valid_o(tag_in_valid), .tag_ready_i(tag_in_ready), .tag_o(tag_in)
  );

  resp_router u_router (
    .clk_i, .arst_n_i,
    .rsp_valid_i, .rsp_ready_o, .rsp_i,
    .tag_valid_i(tag_out_valid), .tag_ready_o(tag_out_ready), .tag_i(tag_out),
    .r_valid_o, .r_ready_i, .r_o,
    .b_valid_o, .b_ready_i, .b_o
  );

endmodule

// File: hdl/bridge_fifo.sv
// Bridge FIFO
// Small synchronous circular buffer, payload type set by parameter

`timescale 1ns/1ns

module bridge_fifo #(
  parameter type payload_t = logic,
  parameter int  depth_p   = 2
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  payload_t                      mem_q [depth_p];
  logic [$clog2(depth_p)-1:0]    wr_ptr_q;
  logic [$clog2(depth_p)-1:0]    rd_ptr_q;
  logic [$clog2(depth_p+1)-1:0]  count_q;
  logic                          push;
  logic                          pop;

  assign in_ready_o  = (count_q != depth_p);
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == depth_p - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == depth_p - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  // Occupancy never passes the depth and agrees with the pointer distance
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (count_q <= depth_p) &&
    ((wr_ptr_q == rd_ptr_q) == ((count_q == '0) || (count_q == depth_p))));

endmodule

// File: hdl/cmd_serializer.sv
// Command serializer
// Merges read and write beats into one memory command stream,
// reads first, and records a return tag per command

`timescale 1ns/1ns

module cmd_serializer (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               rd_valid_i,
  output logic               rd_ready_o,
  input  axi_pkg::axi_beat_t rd_beat_i,
  input  logic               wr_valid_i,
  output logic               wr_ready_o,
  input  axi_pkg::axi_beat_t wr_beat_i,
  input  logic               wd_valid_i,
  output logic               wd_ready_o,
  input  axi_pkg::axi_w_t    wd_i,
  output logic               cmd_valid_o,
  input  logic               cmd_ready_i,
  output mem_pkg::mem_cmd_t  cmd_o,
  output logic               tag_valid_o,
  input  logic               tag_ready_i,
  output mem_pkg::ret_tag_t  tag_o
);

  import axi_pkg::*;

  logic      sel_rd;
  logic      go;
  axi_beat_t beat;

  // A pending read blocks writes even while the tag fifo is full
  assign sel_rd = rd_valid_i;
  assign beat   = sel_rd ? rd_beat_i : wr_beat_i;

  assign cmd_valid_o = tag_ready_i && (rd_valid_i || (wr_valid_i && wd_valid_i));
  assign go          = cmd_ready_i && tag_ready_i;

  assign rd_ready_o = go;
  assign wr_ready_o = go && !sel_rd && wd_valid_i;
  assign wd_ready_o = go && !sel_rd && wr_valid_i;

  localparam int OFS_W = $clog2(AXI_STRB_W);

  assign cmd_o.addr  = {beat.addr[AXI_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  assign cmd_o.data  = sel_rd ? '0 : wd_i.data;
  assign cmd_o.wmask = sel_rd ? '0 : (wd_i.strb & wr_beat_i.mask);
  assign cmd_o.w     = !sel_rd;

  // One tag per accepted command
  assign tag_valid_o = cmd_valid_o && cmd_ready_i;
  assign tag_o.w     = !sel_rd;
  assign tag_o.id    = beat.id;
  assign tag_o.last  = beat.last;

  // W stream framing must line up with the AW burst length
  a_wlast_match: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cmd_valid_o && cmd_ready_i && cmd_o.w) |-> (wd_i.last == wr_beat_i.last));

endmodule

// File: hdl/resp_router.sv
// Response router
// Pairs each in-order memory response with its return tag and
// drives R, or B on the last beat of a write burst

`timescale 1ns/1ns

module resp_router (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              rsp_valid_i,
  output logic              rsp_ready_o,
  input  mem_pkg::mem_rsp_t rsp_i,
  input  logic              tag_valid_i,
  output logic              tag_ready_o,
  input  mem_pkg::ret_tag_t tag_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output axi_pkg::axi_r_t   r_o,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output axi_pkg::axi_b_t   b_o
);

  import axi_pkg::*;

  logic is_rd;
  logic is_b;

  assign is_rd = !tag_i.w;
  assign is_b  = tag_i.w && tag_i.last;

  assign r_valid_o = rsp_valid_i && tag_valid_i && is_rd;
  assign b_valid_o = rsp_valid_i && tag_valid_i && is_b;

  // Non-last write responses are dropped right away
  always_comb begin
    if (!tag_valid_i) begin
      rsp_ready_o = 1'b0;
    end else if (is_rd) begin
      rsp_ready_o = r_ready_i;
    end else if (is_b) begin
      rsp_ready_o = b_ready_i;
    end else begin
      rsp_ready_o = 1'b1;
    end
  end

  // Tag leaves together with its response
  assign tag_ready_o = rsp_valid_i && rsp_ready_o;

  assign r_o.data = rsp_i.data;
  assign r_o.id   = tag_i.id;
  assign r_o.last = tag_i.last;
  assign r_o.resp = AXI_RESP_OKAY;

  assign b_o.id   = tag_i.id;
  assign b_o.resp = AXI_RESP_OKAY;

  // Memory must not answer a command that was never issued
  a_rsp_has_tag: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_i |-> tag_valid_i);

endmodule

// File: sim/axi_to_fifo_checker.sv
// Checker for the AXI4 to FIFO bridge
// Keeps a byte image of memory and predicts memory commands, R and B,
// then compares them with the DUT ports

`timescale 1ns/1ns

module axi_to_fifo_checker (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              ar_valid_i,
  input  logic              ar_ready_i,
  input  axi_pkg::axi_ax_t  ar_i,
  input  logic              aw_valid_i,
  input  logic              aw_ready_i,
  input  axi_pkg::axi_ax_t  aw_i,
  input  logic              w_valid_i,
  input  logic              w_ready_i,
  input  axi_pkg::axi_w_t   w_i,
  input  logic              b_valid_i,
  input  logic              b_ready_i,
  input  axi_pkg::axi_b_t   b_i,
  input  logic              r_valid_i,
  input  logic              r_ready_i,
  input  axi_pkg::axi_r_t   r_i,
  input  logic              cmd_valid_i,
  input  logic              cmd_ready_i,
  input  mem_pkg::mem_cmd_t cmd_i,
  input  logic              rsp_valid_i,
  input  logic              rsp_ready_i,
  input  int                test_num_i,
  input  logic              test_done_i,
  input  logic              report_i,
  output int                errors_o
);

  import axi_pkg::*;
  import mem_pkg::*;

  logic [7:0] img [logic [31:0]];
  axi_ax_t    aw_q [$];
  axi_r_t     r_q [$];
  axi_b_t     b_q [$];
  mem_cmd_t   rd_q [$];
  mem_cmd_t   wr_q [$];
  int         wbeat, pending, n_cmd, n_rsp, mark, passed, failed;

  // Unwritten memory reads back as a pattern of its address
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  // Byte lanes of a naturally aligned access
  function automatic logic [7:0] lanes(input logic [2:0] size, input logic [31:0] a);
    logic [7:0] m;
    m = 8'((16'd1 << (1 << size)) - 16'd1);
    return m << (a[2:0] & (3'h7 << size));
  endfunction

  function automatic logic [63:0] word(input logic [31:0] a);
    logic [63:0] d;
    logic [31:0] b;
    for (int i = 0; i < 8; i++) begin
      b = {a[31:3], 3'(i)};
      d[8*i +: 8] = img.exists(b) ? img[b] : fill_byte(b);
    end
    return d;
  endfunction

  task automatic compare(input string sig, input logic [127:0] exp, input logic [127:0] got);
    if (exp !== got) begin
      $display("mismatch %s: expected %h, got %h", sig, exp, got);
      errors_o++;
    end
  endtask

  // Transfers are sampled mid-cycle, one half period before their edge
  always @(negedge clk_i) begin : watch
    axi_ax_t     a;
    axi_r_t      r;
    axi_b_t      b;
    mem_cmd_t    c;
    logic [31:0] ad;
    logic [7:0]  m;
    if (!arst_n_i) begin
      errors_o = 0;
      wbeat    = 0;
      pending  = 0;
      n_cmd    = 0;
      n_rsp    = 0;
      mark     = 0;
      passed   = 0;
      failed   = 0;
    end else begin
      if (aw_valid_i && aw_ready_i) begin
        aw_q.push_back(aw_i);
        b = {aw_i.id, AXI_RESP_OKAY};
        b_q.push_back(b);
      end
      if (w_valid_i && w_ready_i) begin
        if (aw_q.size() == 0) begin
          $display("W beat arrived with no write address pending");
          errors_o++;
        end else begin
          a  = aw_q[0];
          ad = a.addr + 32'(8 * wbeat);
          m  = w_i.strb & lanes(a.size, ad);
          for (int i = 0; i < 8; i++) begin
            if (m[i]) img[{ad[31:3], 3'(i)}] = w_i.data[8*i +: 8];
          end
          c = {ad[31:3], 3'b000, w_i.data, m, 1'b1};
          wr_q.push_back(c);
          if (wbeat == a.len) begin
            wbeat = 0;
            void'(aw_q.pop_front());
          end else begin
            wbeat++;
          end
        end
      end
      if (ar_valid_i && ar_ready_i) begin
        for (int k = 0; k <= ar_i.len; k++) begin
          ad = ar_i.addr + 32'(8 * k);
          c  = {ad[31:3], 3'b000, 64'd0, 8'd0, 1'b0};
          r  = {word(ad), ar_i.id, (k == ar_i.len), AXI_RESP_OKAY};
          rd_q.push_back(c);
          r_q.push_back(r);
        end
      end
      if (cmd_valid_i && cmd_ready_i) begin
        if (pending >= TAG_FIFO_DEPTH) begin
          $display("command issued with %0d commands outstanding", pending);
          errors_o++;
        end
        n_cmd++;
        pending++;
        if ((cmd_i.w && wr_q.size() == 0) || (!cmd_i.w && rd_q.size() == 0)) begin
          $display("extra memory command at address %h", cmd_i.addr);
          errors_o++;
        end else if (cmd_i.w) begin
          compare("cmd_o", wr_q.pop_front(), cmd_i);
        end else begin
          compare("cmd_o", rd_q.pop_front(), cmd_i);
        end
      end
      if (rsp_valid_i && rsp_ready_i) begin
        n_rsp++;
        pending--;
      end
      if (r_valid_i && r_ready_i) begin
        if (r_q.size() == 0) begin
          $display("extra R beat with id %h", r_i.id);
          errors_o++;
        end else begin
          compare("r_o", r_q.pop_front(), r_i);
        end
      end
      if (b_valid_i && b_ready_i) begin
        if (b_q.size() == 0) begin
          $display("extra B response with id %h", b_i.id);
          errors_o++;
        end else begin
          compare("b_o", b_q.pop_front(), b_i);
        end
      end
      if (test_done_i) begin
        if (r_q.size() + b_q.size() + rd_q.size() + wr_q.size() != 0) begin
          $display("test %0d left %0d R beats, %0d B responses and %0d commands missing",
                   test_num_i, r_q.size(), b_q.size(), rd_q.size() + wr_q.size());
          errors_o++;
        end
        $display("test %0d %s with %0d errors", test_num_i,
                 (errors_o == mark) ? "passed" : "failed", errors_o - mark);
        if (errors_o == mark) passed++;
        else failed++;
        mark = errors_o;
      end
      if (report_i) begin
        if (n_cmd != n_rsp) begin
          $display("memory saw %0d commands but %0d responses", n_cmd, n_rsp);
          errors_o++;
        end
        $display("tests passed %0d, failed %0d, commands %0d, responses %0d, errors %0d",
                 passed, failed, n_cmd, n_rsp, errors_o);
      end
    end
  end

endmodule

// File: sim/axi_to_fifo_tb.sv
// Testbench for the AXI4 to FIFO bridge
// Random AXI traffic from a fixed seed, an in-order memory model with
// random latency, random back-pressure and a cycle limit

`timescale 1ns/1ns

module axi_to_fifo_tb;

  import axi_pkg::*;
  import mem_pkg::*;

  logic     clk_i = 1'b0;
  logic     arst_n_i;
  logic     ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
  logic     b_valid_o, b_ready_i, r_valid_o, r_ready_i;
  logic     cmd_valid_o, cmd_ready_i, rsp_valid_i, rsp_ready_o;
  axi_ax_t  ar_i, aw_i;
  axi_w_t   w_i;
  axi_b_t   b_o;
  axi_r_t   r_o;
  mem_cmd_t cmd_o;
  mem_rsp_t rsp_i;

  int          cycle = 0;
  int          beats = 0;
  int          bp_pct, b_issued, r_issued, b_seen, r_seen, err_cnt;
  int          test_num_i;
  logic        test_done_i, report_i;
  logic [7:0]  mem [logic [31:0]];
  logic [63:0] rsp_q [$];
  int          due_q [$];

  always #50 clk_i = ~clk_i;

  axi_to_fifo UUT (.*);

  axi_to_fifo_checker chk (
    .*,
    .ar_ready_i(ar_ready_o), .aw_ready_i(aw_ready_o), .w_ready_i(w_ready_o),
    .b_valid_i(b_valid_o), .b_i(b_o), .r_valid_i(r_valid_o), .r_i(r_o),
    .cmd_valid_i(cmd_valid_o), .cmd_i(cmd_o), .rsp_ready_i(rsp_ready_o),
    .errors_o(err_cnt)
  );

  // Limit grows with every beat handed to the DUT
  always @(posedge clk_i) begin
    cycle++;
    if (cycle > 40 * beats + 1000) begin
      $display("timeout after %0d cycles with %0d beats issued", cycle, beats);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  // Random word in a 32-word region, aligned to the access size
  function automatic logic [31:0] pick_addr(input logic [31:0] base, input int size);
    logic [31:0] ofs;
    ofs = ($urandom % 8) & ~((1 << size) - 1);
    return base + 32'(8 * ($urandom % 32)) + ofs;
  endfunction

  // Memory model and random ready signals
  initial begin : memory_model
    logic        take, give;
    mem_cmd_t    cmd;
    logic [31:0] a;
    logic [63:0] rd;
    wait (arst_n_i);
    forever begin
      @(negedge clk_i);
      take = cmd_valid_o && cmd_ready_i;
      give = rsp_valid_i && rsp_ready_o;
      cmd  = cmd_o;
      if (b_valid_o && b_ready_i) b_seen++;
      if (r_valid_o && r_ready_i && r_o.last) r_seen++;
      @(posedge clk_i);
      #1;
      if (give) begin
        void'(rsp_q.pop_front());
        void'(due_q.pop_front());
      end
      if (take) begin
        for (int i = 0; i < 8; i++) begin
          a = cmd.addr + 32'(i);
          if (cmd.w && cmd.wmask[i]) mem[a] = cmd.data[8*i +: 8];
          rd[8*i +: 8] = mem.exists(a) ? mem[a] : fill_byte(a);
        end
        rsp_q.push_back(rd);
        due_q.push_back(cycle + int'($urandom % 6));
      end
      rsp_valid_i = (rsp_q.size() > 0) && (due_q[0] <= cycle);
      rsp_i.data  = (rsp_q.size() > 0) ? rsp_q[0] : '0;
      r_ready_i   = ($urandom % 100) >= bp_pct;
      b_ready_i   = ($urandom % 100) >= bp_pct;
      cmd_ready_i = ($urandom % 100) >= bp_pct;
    end
  end

  task automatic write_burst(input logic [31:0] addr, input int len, input int size);
    aw_i = {addr, 4'($urandom), 8'(len), 3'(size), AXI_BURST_INCR};
    aw_valid_i = 1'b1;
    b_issued++;
    beats += len + 1;
    do @(negedge clk_i); while (!aw_ready_o);
    @(posedge clk_i);
    #1;
    aw_valid_i = 1'b0;
    for (int k = 0; k <= len; k++) begin
      w_i = {$urandom, $urandom, 8'($urandom), (k == len)};
      w_valid_i = 1'b1;
      do @(negedge clk_i); while (!w_ready_o);
      @(posedge clk_i);
      #1;
    end
    w_valid_i = 1'b0;
  endtask

  task automatic read_burst(input logic [31:0] addr, input int len, input int size);
    ar_i = {addr, 4'($urandom), 8'(len), 3'(size), AXI_BURST_INCR};
    ar_valid_i = 1'b1;
    r_issued++;
    beats += len + 1;
    do @(negedge clk_i); while (!ar_ready_o);
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b0;
  endtask

  // Wait until every issued burst has its B or its last R
  task automatic drain;
    wait (b_seen == b_issued && r_seen == r_issued);
    @(posedge clk_i);
    #1;
  endtask

  task automatic end_test(input int num);
    test_num_i  = num;
    test_done_i = 1'b1;
    @(posedge clk_i);
    #1;
    test_done_i = 1'b0;
  endtask

  initial begin : stimulus
    int          seed;
    int          len;
    logic [31:0] a;
    seed = 96071;
    void'($urandom(seed));
    {ar_valid_i, aw_valid_i, w_valid_i, b_ready_i, r_ready_i} = '0;
    {cmd_ready_i, rsp_valid_i, test_done_i, report_i} = '0;
    {ar_i, aw_i, w_i, rsp_i} = '0;
    {b_issued, r_issued, b_seen, r_seen, test_num_i} = '0;
    bp_pct   = 30;
    arst_n_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    // Full word write then read back
    a = pick_addr(32'h1000, 3);
    write_burst(a, 0, 3);
    drain();
    read_burst(a, 0, 3);
    drain();
    end_test(1);
    // Narrow writes touch only their strobed lanes
    for (int n = 0; n < 6; n++) begin
      a = pick_addr(32'h1000, n % 3);
      write_burst(a, 0, n % 3);
      drain();
      read_burst({a[31:3], 3'b000}, 0, 3);
      drain();
    end
    end_test(2);
    for (int n = 0; n < 4; n++) begin
      len = $urandom % 8;
      a   = pick_addr(32'h1400, 3);
      write_burst(a, len, 3);
      drain();
      read_burst(a, len, 3);
      drain();
    end
    end_test(3);
    // Back to back bursts, IDs and order
    for (int n = 0; n < 3; n++) write_burst(pick_addr(32'h5000, 3), $urandom % 8, 3);
    for (int n = 0; n < 3; n++) read_burst(pick_addr(32'h1000, 3), $urandom % 8, 3);
    drain();
    end_test(4);
    bp_pct = 70;
    for (int n = 0; n < 6; n++) begin
      len = $urandom % 8;
      a   = pick_addr(32'h1800, 3);
      write_burst(a, len, 3);
      drain();
      read_burst(a, len, 3);
      drain();
    end
    end_test(5);
    // Reads and writes in flight together on disjoint regions
    bp_pct = 30;
    fork
      for (int n = 0; n < 5; n++) write_burst(pick_addr(32'h3000, 3), $urandom % 8, 3);
      for (int n = 0; n < 5; n++) read_burst(pick_addr(32'h1400, 3), $urandom % 8, 3);
    join
    drain();
    end_test(6);
    report_i = 1'b1;
    @(posedge clk_i);
    #1;
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
